// ==== common/video_pkg.sv ====
// line and frame timing constants, STAT mode codes and CPU register offsets
package video_pkg;

	// --------------------
	// line and frame timing

	// clocks per line and lines per frame
	localparam int LINE_CLOCKS   = 456;
	localparam int LINE_COUNT    = 154;
	// first line of vblank
	localparam int VISIBLE_LINES = 144;

	// mode 2 and mode 3 lengths, mode 3 is fixed here
	localparam int OAM_CLOCKS    = 80;
	localparam int DRAW_CLOCKS   = 172;

	// pixels per line, bytes copied by one DMA
	localparam int SCREEN_WIDTH  = 160;
	localparam int OAM_SIZE      = 160;

	// STAT mode field, bits 1:0
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} video_mode_t;

	// --------------------
	// register offsets, low nibble of ff4x
	localparam logic [3:0] REG_LCDC = 4'h0;
	localparam logic [3:0] REG_STAT = 4'h1;
	localparam logic [3:0] REG_SCY  = 4'h2;
	localparam logic [3:0] REG_SCX  = 4'h3;
	localparam logic [3:0] REG_LY   = 4'h4;
	localparam logic [3:0] REG_LYC  = 4'h5;
	localparam logic [3:0] REG_DMA  = 4'h6;
	localparam logic [3:0] REG_BGP  = 4'h7;
	localparam logic [3:0] REG_OBP0 = 4'h8;
	localparam logic [3:0] REG_OBP1 = 4'h9;
	localparam logic [3:0] REG_WY   = 4'ha;
	localparam logic [3:0] REG_WX   = 4'hb;

endpackage

// ==== design/video_timing.sv ====
// dot counter, line counter, LY view and line start strobe
`timescale 1ns/1ps

module video_timing import video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	output logic [8:0] h_cnt,
	output logic [7:0] v_cnt,
	output logic [7:0] ly,
	output logic       line_start
);

	// last dot of a line, last line of a frame
	logic line_end;
	logic frame_end;

	assign line_end  = (h_cnt == 9'(LINE_CLOCKS - 1));
	assign frame_end = (v_cnt == 8'(LINE_COUNT - 1));

	// free running, the counters never stop even with the lcd off
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= 9'd0;
			v_cnt <= 8'd0;
		end else if (line_end) begin
			h_cnt <= 9'd0;
			v_cnt <= frame_end ? 8'd0 : v_cnt + 8'd1;
		end else begin
			h_cnt <= h_cnt + 9'd1;
		end
	end

	// LY follows the line counter, so it steps exactly on the h_cnt wrap
	assign ly = v_cnt;

	// first dot of every line
	assign line_start = (h_cnt == 9'd0);

	a_cnt_range: assert property (@(posedge clk) disable iff (reset)
		(h_cnt < 9'(LINE_CLOCKS)) && (v_cnt < 8'(LINE_COUNT)));

endmodule

// ==== design/video_mode_fsm.sv ====
// STAT mode state machine and STAT interrupt pulse
`timescale 1ns/1ps

module video_mode_fsm import video_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [8:0]  h_cnt,
	input  logic [7:0]  v_cnt,
	input  logic [7:0]  ly,
	input  logic        line_start,
	input  logic [7:0]  lyc,
	input  logic [3:0]  stat_en,
	output video_mode_t mode,
	output logic        irq
);

	video_mode_t mode_next;
	logic [7:0]  v_next;
	logic        visible;
	logic [3:0]  irq_src;

	// line the counters move to after the current one
	assign v_next  = (v_cnt == 8'(LINE_COUNT - 1)) ? 8'd0 : v_cnt + 8'd1;
	assign visible = (v_cnt < 8'(VISIBLE_LINES));

	// step one clock early so mode lines up with h_cnt
	always_comb begin
		mode_next = mode;
		if (h_cnt == 9'(LINE_CLOCKS - 1)) begin
			mode_next = (v_next < 8'(VISIBLE_LINES)) ? MODE_OAM : MODE_VBLANK;
		end else begin
			case (mode)
				MODE_OAM:
					if (h_cnt == 9'(OAM_CLOCKS - 1))
						mode_next = MODE_DRAW;
				MODE_DRAW:
					if (h_cnt == 9'(OAM_CLOCKS + DRAW_CLOCKS - 1))
						mode_next = MODE_HBLANK;
				default:
					mode_next = mode;
			endcase
		end
	end

	// --------------------
	// STAT interrupt sources, stat_en[3:0] is STAT[6:3]

	// bit 6 LY==LYC coincidence
	assign irq_src[3] = stat_en[3] && line_start && (ly == lyc);
	// bit 5 start of mode 2
	assign irq_src[2] = stat_en[2] && line_start && visible;
	// bit 4 first vblank line
	assign irq_src[1] = stat_en[1] && line_start && (v_cnt == 8'(VISIBLE_LINES));
	// bit 3 start of hblank
	assign irq_src[0] = stat_en[0] && visible && (h_cnt == 9'(OAM_CLOCKS + DRAW_CLOCKS));

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= MODE_OAM;
			irq  <= 1'b0;
		end else begin
			mode <= mode_next;
			// one clock pulse, all sources share it
			irq  <= |irq_src;
		end
	end

	a_no_draw_in_vblank: assert property (@(posedge clk) disable iff (reset)
		(mode == MODE_DRAW) |-> (v_cnt < 8'(VISIBLE_LINES)));

endmodule

// ==== design/video_regs.sv ====
// CPU register file for ff40-ff4b and the CPU read data multiplexer
`timescale 1ns/1ps

module video_regs import video_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        cpu_sel_reg,
	input  logic        cpu_sel_oam,
	input  logic [7:0]  cpu_addr,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_di,
	input  logic [7:0]  ly,
	input  video_mode_t mode,
	input  logic [7:0]  oam_do,
	output logic [7:0]  cpu_do,
	output logic [7:0]  lcdc,
	output logic [3:0]  stat_en,
	output logic [7:0]  scx,
	output logic [7:0]  scy,
	output logic [7:0]  lyc,
	output logic [7:0]  bgp,
	output logic [7:0]  dma_page,
	output logic        dma_start
);

	// object palettes and window position, storage only
	logic [7:0] obp0;
	logic [7:0] obp1;
	logic [7:0] wy;
	logic [7:0] wx;

	logic [3:0] offs;
	logic       reg_wr;

	assign offs   = cpu_addr[3:0];
	assign reg_wr = cpu_sel_reg && cpu_wr;

	always_ff @(posedge clk) begin
		if (reset) begin
			// lcd off so boot code can fill vram
			lcdc      <= 8'h00;
			stat_en   <= 4'h0;
			scy       <= 8'h00;
			scx       <= 8'h00;
			lyc       <= 8'h00;
			dma_page  <= 8'h00;
			bgp       <= 8'hfc;
			obp0      <= 8'hff;
			obp1      <= 8'hff;
			wy        <= 8'h00;
			wx        <= 8'h00;
			dma_start <= 1'b0;
		end else begin
			// page is already stored when the pulse reaches the dma engine
			dma_start <= reg_wr && (offs == REG_DMA);
			if (reg_wr) begin
				case (offs)
					REG_LCDC: lcdc     <= cpu_di;
					REG_STAT: stat_en  <= cpu_di[6:3];
					REG_SCY:  scy      <= cpu_di;
					REG_SCX:  scx      <= cpu_di;
					REG_LYC:  lyc      <= cpu_di;
					REG_DMA:  dma_page <= cpu_di;
					REG_BGP:  bgp      <= cpu_di;
					REG_OBP0: obp0     <= cpu_di;
					REG_OBP1: obp1     <= cpu_di;
					REG_WY:   wy       <= cpu_di;
					REG_WX:   wx       <= cpu_di;
					// LY is read only
					default:  ;
				endcase
			end
		end
	end

	// --------------------
	// read mux, same cycle as the address
	always_comb begin
		cpu_do = 8'hff;
		if (cpu_sel_oam) begin
			cpu_do = oam_do;
		end else begin
			case (offs)
				REG_LCDC: cpu_do = lcdc;
				// bit 7 reads as one
				REG_STAT: cpu_do = {1'b1, stat_en, (ly == lyc), mode};
				REG_SCY:  cpu_do = scy;
				REG_SCX:  cpu_do = scx;
				REG_LY:   cpu_do = ly;
				REG_LYC:  cpu_do = lyc;
				REG_DMA:  cpu_do = dma_page;
				REG_BGP:  cpu_do = bgp;
				REG_OBP0: cpu_do = obp0;
				REG_OBP1: cpu_do = obp1;
				REG_WY:   cpu_do = wy;
				REG_WX:   cpu_do = wx;
				default:  cpu_do = 8'hff;
			endcase
		end
	end

endmodule

// ==== design/oam_dma.sv ====
// OAM memory with its CPU port and the OAM DMA copy engine
`timescale 1ns/1ps

module oam_dma import video_pkg::*; #(
	// clocks spent per copied byte, 2 or more
	parameter int DMA_CLOCKS_PER_BYTE = 4
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        cpu_sel_oam,
	input  logic [7:0]  cpu_addr,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_di,
	input  logic        dma_start,
	input  logic [7:0]  dma_page,
	input  logic [7:0]  dma_data,
	output logic [7:0]  oam_do,
	output logic        dma_rd,
	output logic [15:0] dma_addr
);

	localparam int SLOT_W = (DMA_CLOCKS_PER_BYTE > 1) ? $clog2(DMA_CLOCKS_PER_BYTE) : 1;
	localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(DMA_CLOCKS_PER_BYTE - 1);

	logic [7:0]        oam_mem [OAM_SIZE];
	logic              dma_active;
	logic [7:0]        byte_cnt;
	logic [SLOT_W-1:0] slot_cnt;
	logic              slot_end;
	logic              oam_we;
	logic [7:0]        oam_waddr;
	logic [7:0]        oam_wdata;

	assign slot_end = (slot_cnt == SLOT_LAST);

	// --------------------
	// copy engine, a new start restarts from byte 0
	always_ff @(posedge clk) begin
		if (reset) begin
			dma_active <= 1'b0;
			byte_cnt   <= 8'd0;
			slot_cnt   <= '0;
		end else if (dma_start) begin
			dma_active <= 1'b1;
			byte_cnt   <= 8'd0;
			slot_cnt   <= '0;
		end else if (dma_active) begin
			if (slot_end) begin
				slot_cnt <= '0;
				if (byte_cnt == 8'(OAM_SIZE - 1))
					dma_active <= 1'b0;
				else
					byte_cnt <= byte_cnt + 8'd1;
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
			end
		end
	end

	// source address held for the whole slot
	assign dma_addr = {dma_page, byte_cnt};
	assign dma_rd   = dma_active;

	// write port, dma owns it while active and writes on the last slot clock
	assign oam_we    = dma_active ? slot_end : (cpu_sel_oam && cpu_wr);
	assign oam_waddr = dma_active ? byte_cnt : cpu_addr;
	assign oam_wdata = dma_active ? dma_data : cpu_di;

	always_ff @(posedge clk) begin
		if (oam_we && (oam_waddr < 8'(OAM_SIZE)))
			oam_mem[oam_waddr] <= oam_wdata;
	end

	// reads outside fe00-fe9f give ff
	assign oam_do = (cpu_addr < 8'(OAM_SIZE)) ? oam_mem[cpu_addr] : 8'hff;

	// a cpu write during a copy leaves its target byte untouched
	a_no_cpu_write_in_dma: assert property (@(posedge clk) disable iff (reset)
		(dma_active && cpu_sel_oam && cpu_wr && (cpu_addr < 8'(OAM_SIZE)) &&
			(cpu_addr != byte_cnt))
		|=> (oam_mem[$past(cpu_addr)] == $past(oam_mem[cpu_addr])));

endmodule

// ==== bg/bg_fetch.sv ====
// background tile fetcher with VRAM address sequencer, tile latches and pixel shifter
`timescale 1ns/1ps

module bg_fetch import video_pkg::*; #(
	// 8 clock fetch slots per line, 21 covers 160 pixels plus fine scroll
	parameter int FETCH_TILES = 21
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [8:0]  h_cnt,
	input  logic [7:0]  v_cnt,
	input  logic [7:0]  lcdc,
	input  logic [7:0]  scx,
	input  logic [7:0]  scy,
	input  logic [7:0]  vram_data,
	output logic        vram_rd,
	output logic [12:0] vram_addr,
	output logic        pix_valid,
	output logic [1:0]  pix_raw
);

	localparam int FETCH_END = OAM_CLOCKS + 8 * FETCH_TILES;

	logic [8:0]  rel;
	logic [2:0]  phase;
	logic        fetch_active;
	logic [7:0]  bg_line;
	logic [4:0]  map_col;
	logic        tile_a12;
	logic [12:0] map_addr;
	logic [12:0] data_addr;
	logic        load;
	logic [7:0]  tile_num;
	logic [7:0]  tile_lo;
	logic [7:0]  shift_lo;
	logic [7:0]  shift_hi;
	logic [3:0]  bits_left;

	// clocks since the start of mode 3, low bits give the slot phase
	assign rel   = h_cnt - 9'(OAM_CLOCKS);
	assign phase = rel[2:0];

	assign fetch_active = lcdc[7] && (v_cnt < 8'(VISIBLE_LINES)) &&
		(h_cnt >= 9'(OAM_CLOCKS)) && ({1'b0, h_cnt} < 10'(FETCH_END));

	// --------------------
	// address generation

	// background row and column, both wrap at 32 tiles
	assign bg_line = v_cnt + scy;
	assign map_col = scx[7:3] + rel[7:3];
	assign map_addr = {2'b11, lcdc[3], bg_line[7:3], map_col};

	// lcdc bit 4 clear uses signed tile numbers around 9000
	assign tile_a12  = lcdc[4] ? 1'b0 : ~tile_num[7];
	// phase 2 reads plane 0, phase 3 reads plane 1
	assign data_addr = {tile_a12, tile_num, bg_line[2:0], phase[0]};

	// phase 0 map, phase 2 and 3 tile data
	assign vram_rd   = fetch_active && ((phase == 3'd0) || (phase == 3'd2) || (phase == 3'd3));
	assign vram_addr = (phase == 3'd0) ? map_addr : data_addr;

	// data arrives one clock after its address
	always_ff @(posedge clk) begin
		if (fetch_active && (phase == 3'd1))
			tile_num <= vram_data;
		if (fetch_active && (phase == 3'd3))
			tile_lo <= vram_data;
	end

	// --------------------
	// pixel shifter, plane 1 is taken straight from vram on load
	assign load = fetch_active && (phase == 3'd4);

	always_ff @(posedge clk) begin
		if (load) begin
			shift_lo <= tile_lo;
			shift_hi <= vram_data;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end
	end

	// loads come every 8 clocks, so the output runs without gaps
	always_ff @(posedge clk) begin
		if (reset)
			bits_left <= 4'd0;
		else if (load)
			bits_left <= 4'd8;
		else if (bits_left != 4'd0)
			bits_left <= bits_left - 4'd1;
	end

	// msb first
	assign pix_valid = (bits_left != 4'd0);
	assign pix_raw   = {shift_hi[7], shift_lo[7]};

endmodule

// ==== bg/bg_pixel_out.sv ====
// fine scroll skip, pixel counter, BGP palette lookup and LCD strobes
`timescale 1ns/1ps

module bg_pixel_out import video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [8:0] h_cnt,
	input  logic [7:0] lcdc,
	input  logic [7:0] scx,
	input  logic [7:0] bgp,
	input  logic       pix_valid,
	input  logic [1:0] pix_raw,
	output logic       lcd_clkena,
	output logic [1:0] lcd_data
);

	logic [2:0] skip_cnt;
	logic [7:0] pix_cnt;

	// armed one clock before fetching starts
	always_ff @(posedge clk) begin
		if (reset) begin
			skip_cnt <= 3'd0;
			pix_cnt  <= 8'(SCREEN_WIDTH);
		end else if (h_cnt == 9'(OAM_CLOCKS - 1)) begin
			skip_cnt <= scx[2:0];
			pix_cnt  <= 8'd0;
		end else if (pix_valid) begin
			// drop the first scx mod 8 pixels, then count the visible ones
			if (skip_cnt != 3'd0)
				skip_cnt <= skip_cnt - 3'd1;
			else if (pix_cnt != 8'(SCREEN_WIDTH))
				pix_cnt <= pix_cnt + 8'd1;
		end
	end

	assign lcd_clkena = pix_valid && (skip_cnt == 3'd0) && (pix_cnt != 8'(SCREEN_WIDTH));

	// BGP lookup, background disabled gives colour 0
	always_comb begin
		if (!lcdc[0]) begin
			lcd_data = 2'b00;
		end else begin
			case (pix_raw)
				2'b00:   lcd_data = bgp[1:0];
				2'b01:   lcd_data = bgp[3:2];
				2'b10:   lcd_data = bgp[5:4];
				default: lcd_data = bgp[7:6];
			endcase
		end
	end

endmodule

// ==== design/video.sv ====
// video controller top level, connects timing, mode FSM, registers, OAM DMA and background path
`timescale 1ns/1ps

module video import video_pkg::*; #(
	parameter int DMA_CLOCKS_PER_BYTE = 4,
	parameter int FETCH_TILES         = 21
) (
	input  logic        clk,
	input  logic        reset,
	// cpu registers and oam
	input  logic        cpu_sel_reg,
	input  logic        cpu_sel_oam,
	input  logic [7:0]  cpu_addr,
	input  logic        cpu_wr,
	input  logic [7:0]  cpu_di,
	output logic [7:0]  cpu_do,
	// lcd side
	output logic        lcd_on,
	output logic        lcd_clkena,
	output logic [1:0]  lcd_data,
	output logic        irq,
	output video_mode_t mode,
	// vram
	output logic        vram_rd,
	output logic [12:0] vram_addr,
	input  logic [7:0]  vram_data,
	// dma source
	output logic        dma_rd,
	output logic [15:0] dma_addr,
	input  logic [7:0]  dma_data
);

	// --------------------
	// internal wires
	logic [8:0] h_cnt;
	logic [7:0] v_cnt;
	logic [7:0] ly;
	logic       line_start;
	logic [7:0] lcdc;
	logic [3:0] stat_en;
	logic [7:0] scx;
	logic [7:0] scy;
	logic [7:0] lyc;
	logic [7:0] bgp;
	logic [7:0] dma_page;
	logic       dma_start;
	logic [7:0] oam_do;
	logic       pix_valid;
	logic [1:0] pix_raw;

	assign lcd_on = lcdc[7];

	video_timing i_timing (.*);

	video_mode_fsm i_mode_fsm (.*);

	video_regs i_regs (.*);

	oam_dma #(.DMA_CLOCKS_PER_BYTE(DMA_CLOCKS_PER_BYTE)) i_oam_dma (.*);

	bg_fetch #(.FETCH_TILES(FETCH_TILES)) i_bg_fetch (.*);

	bg_pixel_out i_bg_pixel_out (.*);

endmodule

// ==== bench/video_model.svh ====
// testbench VRAM content, reference background pixel model and expected timing values
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

// vram fill, every address bit feeds the byte
function automatic logic [7:0] vram_byte(input logic [12:0] addr);
	logic [15:0] p;
	p = {3'b000, addr} * 16'd151 + 16'h3d29;
	return p[12:5] ^ addr[7:0];
endfunction

// mode expected at a given dot and line
function automatic logic [1:0] expected_mode(input int h, input int v);
	if (v >= VISIBLE_LINES)
		return MODE_VBLANK;
	if (h < OAM_CLOCKS)
		return MODE_OAM;
	if (h < OAM_CLOCKS + DRAW_CLOCKS)
		return MODE_DRAW;
	return MODE_HBLANK;
endfunction

// irq pulses per frame for one STAT source, 0 is bit 3
function automatic int expected_irq_count(input int src);
	case (src)
		0: return VISIBLE_LINES;
		2: return VISIBLE_LINES;
		default: return 1;
	endcase
endfunction

// screen pixel x of a line after scroll, tile lookup and palette
function automatic logic [1:0] model_pixel(input logic [7:0] lcdc, input logic [7:0] scx,
		input logic [7:0] scy, input logic [7:0] bgp, input int line, input int x);
	logic [7:0]  bg_x;
	logic [7:0]  bg_y;
	logic [7:0]  tile;
	logic [7:0]  lo;
	logic [7:0]  hi;
	logic [7:0]  pal;
	logic [12:0] map_addr;
	logic [12:0] data_addr;
	logic [2:0]  bit_n;
	logic [1:0]  raw;
	// both axes wrap at 256
	bg_x = scx + 8'(x);
	bg_y = scy + 8'(line);
	// map at 9800 or 9c00, 32 by 32 tiles
	map_addr = 13'h1800 + (lcdc[3] ? 13'h0400 : 13'h0000);
	map_addr = map_addr + {3'b000, bg_y[7:3], 5'b00000} + {8'h00, bg_x[7:3]};
	tile = vram_byte(map_addr);
	// unsigned from 8000, or signed around 9000
	if (lcdc[4])
		data_addr = {1'b0, tile, 4'h0};
	else
		data_addr = 13'h1000 + {tile[7], tile, 4'h0};
	data_addr = data_addr + {9'd0, bg_y[2:0], 1'b0};
	lo = vram_byte(data_addr);
	hi = vram_byte(data_addr + 13'd1);
	// leftmost pixel is the msb
	bit_n = 3'd7 - bg_x[2:0];
	raw = {hi[bit_n], lo[bit_n]};
	pal = bgp >> {raw, 1'b0};
	return lcdc[0] ? pal[1:0] : 2'b00;
endfunction

`endif

// ==== bench/video_tb.sv ====
// testbench for the video controller with responders, random tests and final report
`timescale 1ns/1ps

module video_tb import video_pkg::*; ();

	localparam int DMA_CLOCKS   = 4;
	localparam int FETCH_TILES  = 21;
	localparam int FRAME_CLOCKS = LINE_CLOCKS * LINE_COUNT;

	logic        clk;
	logic        reset;
	logic        cpu_sel_reg;
	logic        cpu_sel_oam;
	logic [7:0]  cpu_addr;
	logic        cpu_wr;
	logic [7:0]  cpu_di;
	logic [7:0]  cpu_do;
	logic        lcd_on;
	logic        lcd_clkena;
	logic [1:0]  lcd_data;
	logic        irq;
	video_mode_t mode;
	logic        vram_rd;
	logic [12:0] vram_addr;
	logic [7:0]  vram_data = 8'h00;
	logic        dma_rd;
	logic [15:0] dma_addr;
	logic [7:0]  dma_data = 8'h00;

	// expected dot and line, counted from reset
	int exp_h;
	int exp_v;
	int errors;
	int tests_run;
	int tests_failed;
	// pixels seen on the lcd since the last clear
	logic [1:0] pix_q [$];

	`include "video_model.svh"

	video #(
		.DMA_CLOCKS_PER_BYTE(DMA_CLOCKS),
		.FETCH_TILES(FETCH_TILES)
	) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// --------------------
	// memory responders, data one clock after the address
	always @(posedge clk) begin
		vram_data <= #1 vram_byte(vram_addr);
		dma_data  <= #1 dma_addr[7:0] ^ 8'ha5;
	end

	// free running position, 456 dots by 154 lines
	always @(posedge clk) begin
		if (reset) begin
			exp_h <= 0;
			exp_v <= 0;
		end else if (exp_h == LINE_CLOCKS - 1) begin
			exp_h <= 0;
			exp_v <= (exp_v == LINE_COUNT - 1) ? 0 : exp_v + 1;
		end else begin
			exp_h <= exp_h + 1;
		end
	end

	// lcd monitor, every strobe must fall in mode 3
	always @(negedge clk) begin
		if (lcd_clkena) begin
			pix_q.push_back(lcd_data);
			if (expected_mode(exp_h, exp_v) != MODE_DRAW)
				check_value("clkena in draw", 32'(MODE_DRAW), 32'(expected_mode(exp_h, exp_v)));
		end
	end

	// --------------------
	// helpers
	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic timeout_error(input string what);
		errors++;
		$display("Timeout while waiting for %s", what);
	endtask

	task automatic cpu_write(input logic [3:0] offs, input logic [7:0] data);
		@(posedge clk);
		#1;
		cpu_sel_reg = 1'b1;
		cpu_sel_oam = 1'b0;
		cpu_addr    = {4'h4, offs};
		cpu_di      = data;
		cpu_wr      = 1'b1;
		@(posedge clk);
		#1;
		cpu_wr      = 1'b0;
		cpu_sel_reg = 1'b0;
	endtask

	// read data is combinational, taken at the falling edge
	task automatic cpu_read(input logic oam, input logic [7:0] addr, output logic [7:0] data);
		@(posedge clk);
		#1;
		cpu_sel_reg = !oam;
		cpu_sel_oam = oam;
		cpu_addr    = addr;
		cpu_wr      = 1'b0;
		@(negedge clk);
		data = cpu_do;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	// --------------------
	// tests
	task automatic test_registers();
		logic [3:0] offs_list [8] = '{REG_SCY, REG_SCX, REG_LYC, REG_BGP,
			REG_OBP0, REG_OBP1, REG_WY, REG_WX};
		logic [7:0] data;
		logic [7:0] value;
		int start;
		start = errors;
		foreach (offs_list[i]) begin
			data = 8'($urandom);
			cpu_write(offs_list[i], data);
			cpu_read(1'b0, {4'h4, offs_list[i]}, value);
			check_value($sformatf("reg %0h", offs_list[i]), 32'(data), 32'(value));
		end
		// ff4c to ff4f are not mapped
		for (int o = 12; o < 16; o++) begin
			cpu_read(1'b0, {4'h4, 4'(o)}, value);
			check_value($sformatf("unmapped %0h", o), 32'hff, 32'(value));
		end
		finish_test("registers", start);
	endtask

	task automatic test_timing();
		logic [7:0] value;
		int start;
		start = errors;
		for (int i = 0; i < 40; i++) begin
			repeat (1 + $urandom % 5000) @(posedge clk);
			cpu_read(1'b0, {4'h4, REG_LY}, value);
			check_value("ly", 32'(exp_v), 32'(value));
			cpu_read(1'b0, {4'h4, REG_STAT}, value);
			check_value($sformatf("stat mode h %0d v %0d", exp_h, exp_v),
				32'(expected_mode(exp_h, exp_v)), 32'(value[1:0]));
			check_value($sformatf("mode port h %0d v %0d", exp_h, exp_v),
				32'(expected_mode(exp_h, exp_v)), 32'(mode));
		end
		finish_test("timing", start);
	endtask

	task automatic test_interrupts();
		int count;
		int start;
		start = errors;
		for (int src = 0; src < 4; src++) begin
			if (src == 3)
				cpu_write(REG_LYC, 8'($urandom % LINE_COUNT));
			// let pulses of the previous source drain
			cpu_write(REG_STAT, 8'h00);
			repeat (2) @(posedge clk);
			cpu_write(REG_STAT, 8'(1 << (src + 3)));
			repeat (2) @(posedge clk);
			// one full frame holds every source exactly once per period
			count = 0;
			repeat (FRAME_CLOCKS) begin
				@(negedge clk);
				if (irq)
					count++;
			end
			check_value($sformatf("irq count stat bit %0d", src + 3),
				32'(expected_irq_count(src)), 32'(count));
		end
		cpu_write(REG_STAT, 8'h00);
		finish_test("interrupts", start);
	endtask

	task automatic test_dma();
		logic [7:0] page;
		logic [7:0] seen_page;
		logic [7:0] value;
		int n;
		int high;
		int start;
		start = errors;
		page = 8'($urandom);
		seen_page = page;
		cpu_write(REG_DMA, page);
		n = 0;
		while (!dma_rd && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (!dma_rd)
			timeout_error("dma_rd to rise");
		// count the busy clocks, source page must hold throughout
		high = 0;
		while (dma_rd && high < 4 * OAM_SIZE * DMA_CLOCKS) begin
			if (dma_addr[15:8] != page)
				seen_page = dma_addr[15:8];
			high++;
			@(negedge clk);
		end
		if (dma_rd)
			timeout_error("dma_rd to fall");
		check_value("dma length", 32'(OAM_SIZE * DMA_CLOCKS), 32'(high));
		check_value("dma page", 32'(page), 32'(seen_page));
		for (int i = 0; i < OAM_SIZE; i++) begin
			cpu_read(1'b1, 8'(i), value);
			check_value($sformatf("oam %0d", i), 32'(8'(i) ^ 8'ha5), 32'(value));
		end
		finish_test("dma", start);
	endtask

	task automatic test_pixels();
		logic [7:0] lcdc_v;
		logic [7:0] scx_v;
		logic [7:0] scy_v;
		logic [7:0] bgp_v;
		int line;
		int n;
		int reads;
		int start;
		start = errors;
		scx_v  = 8'($urandom);
		scy_v  = 8'($urandom);
		bgp_v  = 8'($urandom);
		// lcd on, random bg enable, map select and tile data select
		lcdc_v = 8'h80 | (8'($urandom) & 8'h19);
		cpu_write(REG_SCX, scx_v);
		cpu_write(REG_SCY, scy_v);
		cpu_write(REG_BGP, bgp_v);
		// switched on inside vblank, so the first fetched line is a whole one
		n = 0;
		while (exp_v < VISIBLE_LINES && n < FRAME_CLOCKS) begin
			@(negedge clk);
			n++;
		end
		if (exp_v < VISIBLE_LINES)
			timeout_error("vblank");
		cpu_write(REG_LCDC, lcdc_v);
		check_value("lcd_on", 32'(lcdc_v[7]), 32'(lcd_on));
		for (int k = 0; k < 3; k++) begin
			n = 0;
			line = -1;
			while (line < 0 && n < FRAME_CLOCKS + LINE_CLOCKS) begin
				@(negedge clk);
				n++;
				if (exp_h == 0 && exp_v < VISIBLE_LINES)
					line = exp_v;
			end
			if (line < 0) begin
				timeout_error("a visible line start");
			end else begin
				pix_q.delete();
				// stop on the last dot of the line, counting vram reads
				reads = 0;
				repeat (LINE_CLOCKS - 1) begin
					@(negedge clk);
					if (vram_rd)
						reads++;
				end
				check_value($sformatf("pixel count line %0d", line),
					32'(SCREEN_WIDTH), 32'(pix_q.size()));
				// map byte and two data bytes per fetch slot
				check_value($sformatf("vram reads line %0d", line),
					32'(3 * FETCH_TILES), 32'(reads));
				foreach (pix_q[x]) begin
					if (x < SCREEN_WIDTH)
						check_value($sformatf("pixel line %0d x %0d", line, x),
							32'(model_pixel(lcdc_v, scx_v, scy_v, bgp_v, line, x)),
							32'(pix_q[x]));
				end
			end
		end
		cpu_write(REG_LCDC, 8'h00);
		check_value("lcd_off", 32'h0, 32'(lcd_on));
		finish_test("pixels", start);
	endtask

	// --------------------
	// main sequence
	initial begin
		void'($urandom(32'ha2a9101c));
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset        = 1'b1;
		cpu_sel_reg  = 1'b0;
		cpu_sel_oam  = 1'b0;
		cpu_addr     = 8'h00;
		cpu_wr       = 1'b0;
		cpu_di       = 8'h00;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_registers();
		test_timing();
		test_interrupts();
		test_dma();
		test_pixels();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+bench
common/video_pkg.sv
design/video_timing.sv
design/video_mode_fsm.sv
design/video_regs.sv
design/oam_dma.sv
bg/bg_fetch.sv
bg/bg_pixel_out.sv
design/video.sv
bench/video_tb.sv

// ==== Makefile ====
# all variables can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= video_tb
SEED_ARGS ?= +verilator+seed+1
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/video_model.svh

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
